// ==== hw/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // register file and queue sizes
    localparam int PHYS_REG_BITS = 6;
    localparam int NUM_PREGS     = 64;
    localparam int NUM_AREGS     = 32;
    localparam int IQ_DEPTH      = 8;
    // every physical register beyond the architectural set starts out free
    localparam int FREE_DEPTH    = NUM_PREGS - NUM_AREGS;

    typedef logic [PHYS_REG_BITS-1:0]     preg_t;
    typedef logic [$clog2(NUM_AREGS)-1:0] areg_t;
    typedef logic [31:0]                  word_t;
    typedef logic [63:0]                  order_t;

    // rv32 base opcodes
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    // M extension marker in funct7
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    // reservation station class picked at dispatch
    typedef enum logic [1:0] {
        rs_alu = 2'd0,
        rs_mul = 2'd1,
        rs_div = 2'd2
    } rs_class_t;

endpackage : rename_pkg

`default_nettype wire

// ==== hw/inst_queue.sv ====
`default_nettype none

module inst_queue import rename_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        push,
    input  wire word_t push_inst,
    input  wire word_t push_pc,
    input  wire        pop,
    output word_t      head_inst,
    output word_t      head_pc,
    output logic       iq_empty,
    output logic       iq_full
);

    word_t                         inst_mem [IQ_DEPTH];
    word_t                         pc_mem   [IQ_DEPTH];
    logic [$clog2(IQ_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(IQ_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(IQ_DEPTH+1)-1:0] count;
    logic                          do_push;
    logic                          do_pop;

    assign iq_empty = (count == 0);
    assign iq_full  = (count == IQ_DEPTH);

    // pushes into a full queue are dropped
    assign do_push = push && !iq_full;
    assign do_pop  = pop && !iq_empty;

    assign head_inst = inst_mem[rd_ptr];
    assign head_pc   = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr] <= push_inst;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    // depth is a power of two, so pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)      count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule : inst_queue

`default_nettype wire

// ==== hw/free_list.sv ====
`default_nettype none

module free_list import rename_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        alloc,
    input  wire        commit,
    input  wire preg_t commit_preg,
    output preg_t      free_preg,
    output logic       fl_empty
);

    preg_t                           fl_mem [FREE_DEPTH];
    logic [$clog2(FREE_DEPTH)-1:0]   head;
    logic [$clog2(FREE_DEPTH)-1:0]   tail;
    logic [$clog2(FREE_DEPTH+1)-1:0] count;
    logic                            do_pop;
    logic                            do_push;

    assign fl_empty  = (count == 0);
    assign free_preg = fl_mem[head];

    assign do_pop  = alloc && !fl_empty;
    // a commit into a full list is only taken when a pop frees a slot
    assign do_push = commit && (count != FREE_DEPTH || do_pop);

    // reset loads p32..p63 in ascending order
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                fl_mem[i] <= preg_t'(NUM_AREGS + i);
            end
        end else if (do_push) begin
            fl_mem[tail] <= commit_preg;
        end
    end

    // the list starts full, so tail begins where head is
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= FREE_DEPTH[$clog2(FREE_DEPTH+1)-1:0];
        end else begin
            if (do_pop)  head <= head + 1'b1;
            if (do_push) tail <= tail + 1'b1;
            case ({do_pop, do_push})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : free_list

`default_nettype wire

// ==== hw/rat.sv ====
`default_nettype none

module rat import rename_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire areg_t rs1,
    input  wire areg_t rs2,
    input  wire areg_t rd,
    input  wire        alloc,
    input  wire preg_t pd,
    input  wire        wb,
    input  wire preg_t wb_preg,
    output preg_t      ps1,
    output preg_t      ps2,
    output logic       ps1_ready,
    output logic       ps2_ready
);

    preg_t                  rat_map [NUM_AREGS];
    logic [NUM_PREGS-1:0]   ready_q;

    // sources see the map before this cycle's update
    assign ps1 = rat_map[rs1];
    assign ps2 = rat_map[rs2];

    // writeback in the same cycle counts as ready
    assign ps1_ready = ready_q[ps1] || (wb && (wb_preg == ps1));
    assign ps2_ready = ready_q[ps2] || (wb && (wb_preg == ps2));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                rat_map[i] <= preg_t'(i);
            end
        end else if (alloc) begin
            rat_map[rd] <= pd;
        end
    end

    // identity mapped registers are ready out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                ready_q[i] <= (i < NUM_AREGS);
            end
        end else begin
            if (wb)    ready_q[wb_preg] <= 1'b1;
            // a fresh destination is pending until its writeback
            if (alloc) ready_q[pd]      <= 1'b0;
        end
    end

endmodule : rat

`default_nettype wire

// ==== hw/rename_dispatch.sv ====
`default_nettype none

module rename_dispatch import rename_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire word_t head_inst,
    input  wire word_t head_pc,
    input  wire        iq_empty,
    input  wire        fl_empty,
    input  wire preg_t free_preg,
    input  wire        rob_full,
    input  wire        rs_full_alu,
    input  wire        rs_full_mul,
    input  wire        rs_full_div,
    input  wire preg_t ps1,
    input  wire preg_t ps2,
    input  wire        ps1_ready,
    input  wire        ps2_ready,
    output logic       pop,
    output logic       alloc,
    output areg_t      rd,
    output areg_t      rs1,
    output areg_t      rs2,
    output preg_t      pd,
    output logic       dispatch,
    output word_t      dispatch_inst,
    output word_t      dispatch_pc,
    output order_t     dispatch_order,
    output rs_class_t  dispatch_class,
    output word_t      dispatch_imm,
    output areg_t      dispatch_rd,
    output preg_t      dispatch_pd,
    output logic       dispatch_regf_we,
    output preg_t      dispatch_ps1,
    output preg_t      dispatch_ps2,
    output logic       dispatch_ps1_ready,
    output logic       dispatch_ps2_ready
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       writes_rd;
    logic       class_full;
    order_t     order_q;

    assign opcode = head_inst[6:0];
    assign funct3 = head_inst[14:12];
    assign funct7 = head_inst[31:25];

    // stores and branches keep immediate bits in the rd field
    assign writes_rd = (opcode != op_store) && (opcode != op_br);
    assign rd  = writes_rd ? head_inst[11:7] : '0;
    assign rs1 = head_inst[19:15];
    assign rs2 = head_inst[24:20];

    // funct3 bit 2 splits mul* from div/rem
    always_comb begin
        dispatch_class = rs_alu;
        if (opcode == op_reg && funct7 == funct7_muldiv) begin
            dispatch_class = funct3[2] ? rs_div : rs_mul;
        end
    end

    always_comb begin
        case (dispatch_class)
            rs_mul:  class_full = rs_full_mul;
            rs_div:  class_full = rs_full_div;
            default: class_full = rs_full_alu;
        endcase
    end

    always_comb begin
        case (opcode)
            op_lui, op_auipc:        dispatch_imm = {head_inst[31:12], 12'h000};
            op_jal:                  dispatch_imm = {{12{head_inst[31]}}, head_inst[19:12],
                                                     head_inst[20], head_inst[30:21], 1'b0};
            op_br:                   dispatch_imm = {{20{head_inst[31]}}, head_inst[7],
                                                     head_inst[30:25], head_inst[11:8], 1'b0};
            op_store:                dispatch_imm = {{21{head_inst[31]}}, head_inst[30:25],
                                                     head_inst[11:7]};
            op_jalr, op_load, op_imm: dispatch_imm = {{21{head_inst[31]}}, head_inst[30:20]};
            default:                 dispatch_imm = '0;
        endcase
    end

    // x0 destinations go ahead even with an empty free list
    assign dispatch = !iq_empty && !rob_full && !class_full && (!fl_empty || rd == '0);
    assign pop      = dispatch;
    assign alloc    = dispatch && (rd != '0);
    assign pd       = (rd != '0) ? free_preg : '0;

    assign dispatch_inst      = head_inst;
    assign dispatch_pc        = head_pc;
    assign dispatch_order     = order_q;
    assign dispatch_rd        = rd;
    assign dispatch_pd        = pd;
    assign dispatch_regf_we   = alloc;
    assign dispatch_ps1       = ps1;
    assign dispatch_ps2       = ps2;
    assign dispatch_ps1_ready = ps1_ready;
    assign dispatch_ps2_ready = ps2_ready;

    // program order tag
    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= '0;
        end else if (dispatch) begin
            order_q <= order_q + 64'd1;
        end
    end

endmodule : rename_dispatch

`default_nettype wire

// ==== hw/rename_top.sv ====
`default_nettype none

module rename_top import rename_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        push,
    input  wire word_t push_inst,
    input  wire word_t push_pc,
    input  wire        rob_full,
    input  wire        rs_full_alu,
    input  wire        rs_full_mul,
    input  wire        rs_full_div,
    input  wire        commit,
    input  wire preg_t commit_preg,
    input  wire        wb,
    input  wire preg_t wb_preg,
    output logic       iq_full,
    output logic       dispatch,
    output word_t      dispatch_inst,
    output word_t      dispatch_pc,
    output order_t     dispatch_order,
    output rs_class_t  dispatch_class,
    output word_t      dispatch_imm,
    output areg_t      dispatch_rd,
    output preg_t      dispatch_pd,
    output logic       dispatch_regf_we,
    output preg_t      dispatch_ps1,
    output preg_t      dispatch_ps2,
    output logic       dispatch_ps1_ready,
    output logic       dispatch_ps2_ready
);

    word_t head_inst;
    word_t head_pc;
    logic  iq_empty;
    logic  pop;
    preg_t free_preg;
    logic  fl_empty;
    logic  alloc;
    areg_t rs1;
    areg_t rs2;
    areg_t rd;
    preg_t pd;
    preg_t ps1;
    preg_t ps2;
    logic  ps1_ready;
    logic  ps2_ready;

    inst_queue u_iq (
        .clk(clk), .rst(rst), .push(push), .push_inst(push_inst), .push_pc(push_pc),
        .pop(pop), .head_inst(head_inst), .head_pc(head_pc), .iq_empty(iq_empty),
        .iq_full(iq_full)
    );

    free_list u_fl (
        .clk(clk), .rst(rst), .alloc(alloc), .commit(commit), .commit_preg(commit_preg),
        .free_preg(free_preg), .fl_empty(fl_empty)
    );

    rat u_rat (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .alloc(alloc), .pd(pd),
        .wb(wb), .wb_preg(wb_preg), .ps1(ps1), .ps2(ps2), .ps1_ready(ps1_ready),
        .ps2_ready(ps2_ready)
    );

    rename_dispatch u_disp (
        .clk(clk), .rst(rst), .head_inst(head_inst), .head_pc(head_pc),
        .iq_empty(iq_empty), .fl_empty(fl_empty), .free_preg(free_preg),
        .rob_full(rob_full), .rs_full_alu(rs_full_alu), .rs_full_mul(rs_full_mul),
        .rs_full_div(rs_full_div), .ps1(ps1), .ps2(ps2), .ps1_ready(ps1_ready),
        .ps2_ready(ps2_ready), .pop(pop), .alloc(alloc), .rd(rd), .rs1(rs1), .rs2(rs2),
        .pd(pd), .dispatch(dispatch), .dispatch_inst(dispatch_inst),
        .dispatch_pc(dispatch_pc), .dispatch_order(dispatch_order),
        .dispatch_class(dispatch_class), .dispatch_imm(dispatch_imm),
        .dispatch_rd(dispatch_rd), .dispatch_pd(dispatch_pd),
        .dispatch_regf_we(dispatch_regf_we), .dispatch_ps1(dispatch_ps1),
        .dispatch_ps2(dispatch_ps2), .dispatch_ps1_ready(dispatch_ps1_ready),
        .dispatch_ps2_ready(dispatch_ps2_ready)
    );

endmodule : rename_top

`default_nettype wire

// ==== verification/rename_properties.sv ====
`default_nettype none

module rename_properties import rename_pkg::*; (
    input wire         clk,
    input wire         rst,
    input wire         dispatch,
    input wire         rob_full,
    input wire preg_t  dispatch_pd,
    input wire         dispatch_regf_we,
    input wire order_t dispatch_order
);

    int unsigned fail_count = 0;

    a_no_rob_full: assert property (@(posedge clk) disable iff (rst) dispatch |-> !rob_full)
        else begin
            fail_count++;
            $error("dispatch fired while the ROB is full");
        end

    // x0 destinations and stores carry no physical register
    a_pd_zero: assert property (@(posedge clk) disable iff (rst)
        dispatch && !dispatch_regf_we |-> dispatch_pd == '0)
        else begin
            fail_count++;
            $error("dispatch_pd is not zero without a register write");
        end

    a_order_step: assert property (@(posedge clk) disable iff (rst)
        dispatch |=> dispatch_order == $past(dispatch_order) + 64'd1)
        else begin
            fail_count++;
            $error("order tag did not step by one after a dispatch");
        end

    a_order_hold: assert property (@(posedge clk) disable iff (rst)
        !dispatch |=> $stable(dispatch_order))
        else begin
            fail_count++;
            $error("order tag changed without a dispatch");
        end

    a_quiet_after_reset: assert property (@(posedge clk) rst |=> !dispatch)
        else begin
            fail_count++;
            $error("dispatch high in the cycle after reset");
        end

endmodule : rename_properties

bind rename_dispatch rename_properties props (
    .clk(clk), .rst(rst), .dispatch(dispatch), .rob_full(rob_full),
    .dispatch_pd(dispatch_pd), .dispatch_regf_we(dispatch_regf_we),
    .dispatch_order(dispatch_order)
);

`default_nettype wire

// ==== verification/rename_tb.sv ====
`default_nettype none

module rename_tb import rename_pkg::*; ();

    typedef struct {
        logic       push;
        word_t      inst;
        word_t      pc;
        logic [1:0] cls;
        word_t      imm;
        logic       rob_full;
        logic       full_alu;
        logic       full_mul;
        logic       full_div;
        logic       commit;
        preg_t      commit_preg;
        logic       wb;
        preg_t      wb_preg;
    } stim_t;

    logic      clk;
    logic      rst;
    logic      push;
    word_t     push_inst;
    word_t     push_pc;
    logic      rob_full;
    logic      rs_full_alu;
    logic      rs_full_mul;
    logic      rs_full_div;
    logic      commit;
    preg_t     commit_preg;
    logic      wb;
    preg_t     wb_preg;
    logic      iq_full;
    logic      dispatch;
    word_t     dispatch_inst;
    word_t     dispatch_pc;
    order_t    dispatch_order;
    rs_class_t dispatch_class;
    word_t     dispatch_imm;
    areg_t     dispatch_rd;
    preg_t     dispatch_pd;
    logic      dispatch_regf_we;
    preg_t     dispatch_ps1;
    preg_t     dispatch_ps2;
    logic      dispatch_ps1_ready;
    logic      dispatch_ps2_ready;

    // reference model of queue, map, free list and ready bits
    stim_t     stim [$];
    stim_t     model_q [$];
    preg_t     model_map [NUM_AREGS];
    logic      model_ready [NUM_PREGS];
    preg_t     model_free [$];
    order_t    model_order;
    int        cycle_count;
    int        cycle_limit;

    rename_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("timeout: run went past %0d cycles", cycle_limit);
                $display("STATUS: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, actual,
                     expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    fields;
        string line;
        stim_t s;
        fd = $fopen("verification/rename_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/rename_stim.txt");
            $display("STATUS: FAIL");
            $fatal(1, "missing stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 s.push, s.inst, s.pc, s.cls, s.imm, s.rob_full,
                                 s.full_alu, s.full_mul, s.full_div, s.commit,
                                 s.commit_preg, s.wb, s.wb_preg);
                if (fields != 13) begin
                    $display("malformed stimulus line: %s", line);
                    $display("STATUS: FAIL");
                    $fatal(1, "bad stimulus file");
                end
                stim.push_back(s);
            end
        end
        $fclose(fd);
    endtask

    task automatic reset_model();
        for (int r = 0; r < NUM_AREGS; r++) begin
            model_map[r] = preg_t'(r);
        end
        for (int p = 0; p < NUM_PREGS; p++) begin
            model_ready[p] = (p < NUM_AREGS);
        end
        model_free.delete();
        for (int p = NUM_AREGS; p < NUM_PREGS; p++) begin
            model_free.push_back(preg_t'(p));
        end
        model_order = '0;
    endtask

    task automatic drive_inputs(input stim_t s);
        push        = s.push;
        push_inst   = s.inst;
        push_pc     = s.pc;
        rob_full    = s.rob_full;
        rs_full_alu = s.full_alu;
        rs_full_mul = s.full_mul;
        rs_full_div = s.full_div;
        commit      = s.commit;
        commit_preg = s.commit_preg;
        wb          = s.wb;
        wb_preg     = s.wb_preg;
    endtask

    // compare this cycle's outputs, then move the model past the next edge
    task automatic check_and_advance(input stim_t s);
        logic       expect_fire;
        logic       class_busy;
        logic       accept;
        logic [6:0] opc;
        areg_t      rd;
        preg_t      pd;
        preg_t      ps1;
        preg_t      ps2;
        stim_t      head;
        expect_fire = 1'b0;
        rd = '0;
        pd = '0;
        accept = s.push && (model_q.size() < IQ_DEPTH);
        check_value(iq_full, model_q.size() == IQ_DEPTH, "iq_full level");
        if (model_q.size() > 0) begin
            head = model_q[0];
            opc = head.inst[6:0];
            // stores and branches name no destination
            rd = (opc == op_store || opc == op_br) ? areg_t'(0) : head.inst[11:7];
            case (head.cls)
                2'd1:    class_busy = s.full_mul;
                2'd2:    class_busy = s.full_div;
                default: class_busy = s.full_alu;
            endcase
            expect_fire = !s.rob_full && !class_busy && (model_free.size() > 0 || rd == 0);
        end
        check_value(dispatch, expect_fire, "dispatch strobe");
        if (expect_fire) begin
            pd = (rd != 0) ? model_free[0] : preg_t'(0);
            ps1 = model_map[head.inst[19:15]];
            ps2 = model_map[head.inst[24:20]];
            check_value(dispatch_inst, head.inst, "dispatch_inst");
            check_value(dispatch_pc, head.pc, "dispatch_pc");
            check_value(dispatch_order, model_order, "dispatch_order");
            check_value(dispatch_class, head.cls, "dispatch_class");
            check_value(dispatch_imm, head.imm, "dispatch_imm");
            check_value(dispatch_rd, rd, "dispatch_rd");
            check_value(dispatch_pd, pd, "dispatch_pd");
            check_value(dispatch_regf_we, rd != 0, "dispatch_regf_we");
            check_value(dispatch_ps1, ps1, "dispatch_ps1");
            check_value(dispatch_ps2, ps2, "dispatch_ps2");
            check_value(dispatch_ps1_ready, model_ready[ps1] || (s.wb && s.wb_preg == ps1),
                        "dispatch_ps1_ready");
            check_value(dispatch_ps2_ready, model_ready[ps2] || (s.wb && s.wb_preg == ps2),
                        "dispatch_ps2_ready");
        end
        if (s.wb) model_ready[s.wb_preg] = 1'b1;
        if (expect_fire) begin
            void'(model_q.pop_front());
            model_order++;
            if (rd != 0) begin
                void'(model_free.pop_front());
                model_map[rd] = pd;
                model_ready[pd] = 1'b0;
            end
        end
        if (s.commit) model_free.push_back(s.commit_preg);
        if (accept) model_q.push_back(s);
    endtask

    initial begin
        stim_t idle;
        void'($urandom(32'h863523ae));
        idle = '{default: '0};
        rst = 1'b1;
        cycle_count = 0;
        cycle_limit = 1000;
        drive_inputs(idle);
        read_stimulus();
        cycle_limit = stim.size() + IQ_DEPTH + 20;
        reset_model();
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        foreach (stim[i]) begin
            @(posedge clk);
            #5;
            drive_inputs(stim[i]);
            #30;
            check_and_advance(stim[i]);
        end
        check_value(model_q.size(), 0, "instructions never dispatched");
        if (uut.u_disp.props.fail_count != 0) begin
            $display("%0d assertion failures during the run", uut.u_disp.props.fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "assertion failures");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule : rename_tb

`default_nettype wire

// ==== verification/rename_stim.txt ====
# push inst pc class imm rob_full full_alu full_mul full_div commit commit_preg wb wb_preg
# one line per cycle, all hex, class 0 alu 1 mul 2 div
1 023100b3 00001000 1 00000000 0 0 0 0 0 00 0 00
1 02409133 00001004 1 00000000 0 0 0 0 0 00 0 00
1 0220c1b3 00001008 2 00000000 0 0 0 0 0 00 0 00
1 0211f1b3 0000100c 2 00000000 0 0 0 0 0 00 1 20
1 00118233 00001010 0 00000000 0 0 0 0 0 00 1 22
1 fff20293 00001014 0 ffffffff 0 0 0 0 0 00 0 00
1 0050a423 00001018 0 00000008 0 0 0 0 0 00 0 00
1 fe208ee3 0000101c 0 fffffffc 0 0 0 0 0 00 0 00
1 12345337 00001020 0 12345000 0 0 0 0 0 00 0 00
1 0100006f 00001024 0 00000010 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00
1 002083b3 00001028 0 00000000 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 1 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 1 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 1 0 0 0 00 0 00
1 02738433 0000102c 1 00000000 0 0 1 1 0 00 0 00
0 00000000 00000000 0 00000000 0 0 1 0 0 00 0 00
0 00000000 00000000 0 00000000 0 1 0 1 0 00 0 00
1 00148493 00001030 0 00000001 1 0 0 0 0 00 0 00
1 ff812503 00001034 0 fffffff8 1 0 0 0 0 00 0 00
1 abcde597 00001038 0 abcde000 1 0 0 0 0 00 0 00
1 7ff08667 0000103c 0 000007ff 1 0 0 0 0 00 0 00
1 00148493 00001040 0 00000001 1 0 0 0 0 00 0 00
1 00148493 00001044 0 00000001 1 0 0 0 0 00 0 00
1 02738433 00001048 1 00000000 1 0 0 0 0 00 0 00
1 0220c1b3 0000104c 2 00000000 1 0 0 0 0 00 0 00
1 00148493 00001050 0 00000001 1 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00
1 00148493 00001054 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001058 0 00000001 0 0 0 0 0 00 0 00
1 00148493 0000105c 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001060 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001064 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001068 0 00000001 0 0 0 0 0 00 0 00
1 00148493 0000106c 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001070 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001074 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001078 0 00000001 0 0 0 0 0 00 0 00
1 00148493 0000107c 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001080 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001084 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001088 0 00000001 0 0 0 0 0 00 0 00
1 00148493 0000108c 0 00000001 0 0 0 0 0 00 0 00
1 00148493 00001090 0 00000001 0 0 0 0 0 00 0 00
1 00118233 00001094 0 00000000 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 1 01 0 00
0 00000000 00000000 0 00000000 0 0 0 0 1 02 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00
0 00000000 00000000 0 00000000 0 0 0 0 0 00 0 00

// ==== verilog.f ====
hw/rename_pkg.sv
hw/inst_queue.sv
hw/free_list.sv
hw/rat.sv
hw/rename_dispatch.sv
hw/rename_top.sv
verification/rename_properties.sv
verification/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_dispatch

sources:
  - hw/rename_pkg.sv
  - hw/inst_queue.sv
  - hw/free_list.sv
  - hw/rat.sv
  - hw/rename_dispatch.sv
  - hw/rename_top.sv
  - target: simulation
    files:
      - verification/rename_properties.sv
      - verification/rename_tb.sv
